// ==== source/dispatch_consts.svh ====
// Dispatcher constants

`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// --------------------------------------------------
// Array geometry
// --------------------------------------------------

// Lanes per edge, matrix size and wave count
`define ARRAY_DIM 6

// Single-precision operand width
`define FLOAT_W 32

// --------------------------------------------------
// Buffering
// --------------------------------------------------

`define BUF_DEPTH 4     // Items between sequencer and edge driver

`endif

// ==== source/dispatch_pkg.sv ====
// Dispatcher types

`include "dispatch_consts.svh"

package dispatch_pkg;

    // Opaque operand word
    typedef logic [`FLOAT_W-1:0] float_sp_t;

    // Lane and wave indices
    typedef logic [$clog2(`ARRAY_DIM)-1:0] lane_t;
    typedef logic [$clog2(`ARRAY_DIM)-1:0] step_t;

    // Operand sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,       // Waiting for start
        SEQ_RUN,        // Issuing one item per cycle
        SEQ_HOLD        // Stalled by back-pressure
    } seq_state_e;

endpackage : dispatch_pkg

// ==== source/operand_sequencer.sv ====
// Operand sequencer

`timescale 1ns/1ns

`include "dispatch_consts.svh"

module operand_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    output logic                   ack_o,

    // Register file read
    output dispatch_pkg::lane_t     rd_lane_o,
    output dispatch_pkg::step_t     rd_step_o,
    input  dispatch_pkg::float_sp_t a_elem_i,   // A[lane][step]
    input  dispatch_pkg::float_sp_t b_elem_i,   // B[step][lane]

    // Item out
    output logic                   valid_o,
    input  logic                   ready_i,
    output dispatch_pkg::lane_t     lane_o,
    output dispatch_pkg::float_sp_t a_o,
    output dispatch_pkg::float_sp_t b_o,
    output logic                   last_o
);

    localparam dispatch_pkg::lane_t LAST_LANE  = dispatch_pkg::lane_t'(`ARRAY_DIM - 1);
    localparam dispatch_pkg::step_t FIRST_STEP = dispatch_pkg::step_t'(`ARRAY_DIM - 1);

    dispatch_pkg::seq_state_e state;
    dispatch_pkg::lane_t      lane_q;
    dispatch_pkg::step_t      step_q;
    logic                     xfer;

    // --------------------------------------------------
    // Item presentation
    // --------------------------------------------------

    assign rd_lane_o = lane_q;
    assign rd_step_o = step_q;

    assign valid_o = (state != dispatch_pkg::SEQ_IDLE);
    assign ack_o   = (state != dispatch_pkg::SEQ_IDLE);
    assign lane_o  = lane_q;
    assign a_o     = a_elem_i;      // Register file answers in the same cycle
    assign b_o     = b_elem_i;
    assign last_o  = (step_q == '0) && (lane_q == LAST_LANE);

    assign xfer = valid_o && ready_i;

    // --------------------------------------------------
    // Wave and lane counters
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_q <= '0;
            step_q <= FIRST_STEP;
        end
        else if (xfer) begin
            if (last_o) begin
                lane_q <= '0;                   // Ready for the next run
                step_q <= FIRST_STEP;
            end
            else if (lane_q == LAST_LANE) begin
                lane_q <= '0;
                step_q <= step_q - 1'b1;        // Next wave
            end
            else begin
                lane_q <= lane_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dispatch_pkg::SEQ_IDLE;
        end
        else begin
            unique case (state)
                dispatch_pkg::SEQ_IDLE: begin
                    if (start_i) begin
                        state <= dispatch_pkg::SEQ_RUN;
                    end
                end
                dispatch_pkg::SEQ_RUN,
                dispatch_pkg::SEQ_HOLD: begin
                    if (!ready_i) begin
                        state <= dispatch_pkg::SEQ_HOLD;
                    end
                    else if (last_o) begin
                        state <= dispatch_pkg::SEQ_IDLE;
                    end
                    else begin
                        state <= dispatch_pkg::SEQ_RUN;
                    end
                end
                default: state <= dispatch_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Stalled item must wait unchanged for its transfer
    assert property (@(posedge clk) disable iff (rst)
        (valid_o && !ready_i) |=> (valid_o && $stable(lane_o)));

endmodule : operand_sequencer

// ==== source/dispatch_fifo.sv ====
// Item FIFO

`timescale 1ns/1ns

`include "dispatch_consts.svh"

module dispatch_fifo #(
    parameter int DEPTH = `BUF_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,

    // Write side
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  dispatch_pkg::lane_t     in_lane_i,
    input  dispatch_pkg::float_sp_t in_a_i,
    input  dispatch_pkg::float_sp_t in_b_i,
    input  logic                   in_last_i,

    // Read side
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output dispatch_pkg::lane_t     out_lane_o,
    output dispatch_pkg::float_sp_t out_a_o,
    output dispatch_pkg::float_sp_t out_b_o,
    output logic                   out_last_o
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int ITEM_W = $bits(dispatch_pkg::lane_t) + 2 * `FLOAT_W + 1;

    logic [ITEM_W-1:0] mem [DEPTH];     // {lane, a, b, last}
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign in_ready_o  = (count != CNT_W'(DEPTH));
    assign out_valid_o = (count != '0);

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    // Head of queue
    assign {out_lane_o, out_a_o, out_b_o, out_last_o} = mem[rd_ptr];

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_lane_i, in_a_i, in_b_i, in_last_i};
        end
    end

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Idle or push with pop
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

endmodule : dispatch_fifo

// ==== source/edge_driver.sv ====
// Array edge driver

`timescale 1ns/1ns

`include "dispatch_consts.svh"

module edge_driver (
    input  logic                   clk,
    input  logic                   rst,

    // Items from the FIFO
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  dispatch_pkg::lane_t     in_lane_i,
    input  dispatch_pkg::float_sp_t in_a_i,
    input  dispatch_pkg::float_sp_t in_b_i,
    input  logic                   in_last_i,

    // Array side
    input  logic                   array_busy_i,
    output logic [`ARRAY_DIM-1:0]  row_req_o,
    output logic [`ARRAY_DIM-1:0]  col_req_o,
    output logic [`ARRAY_DIM*`FLOAT_W-1:0] row_data_o,
    output logic [`ARRAY_DIM*`FLOAT_W-1:0] col_data_o,
    output logic                   done_o
);

    logic                  wave_blocked;
    logic                  take;
    logic [`ARRAY_DIM-1:0] lane_sel;

    // --------------------------------------------------
    // Wave start gating
    // --------------------------------------------------

    // Lane 0 opens a wave, which waits for an idle array
    assign wave_blocked = in_valid_i && (in_lane_i == '0) && array_busy_i;
    assign in_ready_o   = !wave_blocked;
    assign take         = in_valid_i && in_ready_o;

    // One-hot lane select that stays zero when nothing is taken
    always_comb begin
        for (int l = 0; l < `ARRAY_DIM; l++) begin
            lane_sel[l] = take && (in_lane_i == dispatch_pkg::lane_t'(l));
        end
    end

    // --------------------------------------------------
    // Registered strobes and data slots
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            row_req_o  <= '0;
            col_req_o  <= '0;
            row_data_o <= '0;
            col_data_o <= '0;
            done_o     <= 1'b0;
        end
        else begin
            row_req_o <= lane_sel;
            col_req_o <= lane_sel;
            for (int l = 0; l < `ARRAY_DIM; l++) begin
                row_data_o[l*`FLOAT_W +: `FLOAT_W] <= lane_sel[l] ? in_a_i : '0;
                col_data_o[l*`FLOAT_W +: `FLOAT_W] <= lane_sel[l] ? in_b_i : '0;
            end
            done_o <= take && in_last_i;    // With the final strobe
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0(row_req_o) && (row_req_o == col_req_o));

endmodule : edge_driver

// ==== source/mpu_dispatch_top.sv ====
// Matrix dispatcher top

`timescale 1ns/1ns

`include "dispatch_consts.svh"

module mpu_dispatch_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    output logic                   ack_o,

    // Register file
    output dispatch_pkg::lane_t     rd_lane_o,
    output dispatch_pkg::step_t     rd_step_o,
    input  dispatch_pkg::float_sp_t a_elem_i,
    input  dispatch_pkg::float_sp_t b_elem_i,

    // FMA array edges
    input  logic                   array_busy_i,
    output logic [`ARRAY_DIM-1:0]  row_req_o,
    output logic [`ARRAY_DIM-1:0]  col_req_o,
    output logic [`ARRAY_DIM*`FLOAT_W-1:0] row_data_o,
    output logic [`ARRAY_DIM*`FLOAT_W-1:0] col_data_o,
    output logic                   done_o
);

    // Sequencer to FIFO
    logic                    seq_valid;
    logic                    seq_ready;
    dispatch_pkg::lane_t     seq_lane;
    dispatch_pkg::float_sp_t seq_a;
    dispatch_pkg::float_sp_t seq_b;
    logic                    seq_last;

    // FIFO to edge driver
    logic                    buf_valid;
    logic                    buf_ready;
    dispatch_pkg::lane_t     buf_lane;
    dispatch_pkg::float_sp_t buf_a;
    dispatch_pkg::float_sp_t buf_b;
    logic                    buf_last;

    // --------------------------------------------------
    // Producer, buffer, consumer
    // --------------------------------------------------

    operand_sequencer i_operand_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start_i),
        .ack_o     (ack_o),
        .rd_lane_o (rd_lane_o),
        .rd_step_o (rd_step_o),
        .a_elem_i  (a_elem_i),
        .b_elem_i  (b_elem_i),
        .valid_o   (seq_valid),
        .ready_i   (seq_ready),
        .lane_o    (seq_lane),
        .a_o       (seq_a),
        .b_o       (seq_b),
        .last_o    (seq_last)
    );

    dispatch_fifo #(
        .DEPTH (`BUF_DEPTH)
    ) i_dispatch_fifo (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (seq_valid),
        .in_ready_o  (seq_ready),
        .in_lane_i   (seq_lane),
        .in_a_i      (seq_a),
        .in_b_i      (seq_b),
        .in_last_i   (seq_last),
        .out_valid_o (buf_valid),
        .out_ready_i (buf_ready),
        .out_lane_o  (buf_lane),
        .out_a_o     (buf_a),
        .out_b_o     (buf_b),
        .out_last_o  (buf_last)
    );

    edge_driver i_edge_driver (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (buf_valid),
        .in_ready_o   (buf_ready),
        .in_lane_i    (buf_lane),
        .in_a_i       (buf_a),
        .in_b_i       (buf_b),
        .in_last_i    (buf_last),
        .array_busy_i (array_busy_i),
        .row_req_o    (row_req_o),
        .col_req_o    (col_req_o),
        .row_data_o   (row_data_o),
        .col_data_o   (col_data_o),
        .done_o       (done_o)
    );

endmodule : mpu_dispatch_top

// ==== testbench/tb_mpu_dispatch.sv ====
// Matrix dispatcher testbench

`timescale 1ns/1ns

`include "dispatch_consts.svh"

module tb_mpu_dispatch;

    localparam int DIM       = `ARRAY_DIM;
    localparam int FW        = `FLOAT_W;
    localparam int N_STROBES = DIM * DIM;
    localparam int RUN_LIMIT = 2000;        // Cycles allowed for one run
    localparam int ACK_LIMIT = 20;
    localparam int QUIET_WIN = 40;
    localparam logic [31:0] LFSR_SEED = 32'heacc;

    logic                    clk;
    logic                    rst;
    logic                    start_i;
    logic                    ack_o;
    dispatch_pkg::lane_t     rd_lane_o;
    dispatch_pkg::step_t     rd_step_o;
    dispatch_pkg::float_sp_t a_elem_i;
    dispatch_pkg::float_sp_t b_elem_i;
    logic                    array_busy_i;
    logic [DIM-1:0]          row_req_o;
    logic [DIM-1:0]          col_req_o;
    logic [DIM*FW-1:0]       row_data_o;
    logic [DIM*FW-1:0]       col_data_o;
    logic                    done_o;

    dispatch_pkg::float_sp_t a_mat [DIM][DIM];     // A[lane][step]
    dispatch_pkg::float_sp_t b_mat [DIM][DIM];     // B[step][lane]
    logic [31:0]             lfsr;
    int                      pass_count;
    int                      fail_count;

    mpu_dispatch_top i_mpu_dispatch_top (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .ack_o        (ack_o),
        .rd_lane_o    (rd_lane_o),
        .rd_step_o    (rd_step_o),
        .a_elem_i     (a_elem_i),
        .b_elem_i     (b_elem_i),
        .array_busy_i (array_busy_i),
        .row_req_o    (row_req_o),
        .col_req_o    (col_req_o),
        .row_data_o   (row_data_o),
        .col_data_o   (col_data_o),
        .done_o       (done_o)
    );

    // Register file model with combinational read
    assign a_elem_i = a_mat[rd_lane_o][rd_step_o];
    assign b_elem_i = b_mat[rd_step_o][rd_lane_o];

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input string test, input string what,
                            input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s expected %0h actual %0h", test, what, exp, act);
            fail_count++;
        end
        else begin
            pass_count++;
        end
    endtask

    task automatic report_failure(input string test, input string msg);
        $display("ERROR %s: %s", test, msg);
        fail_count++;
    endtask

    task automatic summarize_test(input string test, input int fails_before);
        $display("Test %s finished with %0d errors", test, fail_count - fails_before);
    endtask

    // Lane out of range means every slot is expected zero
    task automatic check_slots(input string test, input int lane, input int step);
        dispatch_pkg::float_sp_t exp_a;
        dispatch_pkg::float_sp_t exp_b;
        for (int j = 0; j < DIM; j++) begin
            exp_a = (j == lane) ? a_mat[lane][step] : '0;
            exp_b = (j == lane) ? b_mat[step][lane] : '0;
            check_eq(test, $sformatf("row_data[%0d]", j), exp_a, row_data_o[j*FW +: FW]);
            check_eq(test, $sformatf("col_data[%0d]", j), exp_b, col_data_o[j*FW +: FW]);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
    endtask

    // --------------------------------------------------
    // Run follower
    // --------------------------------------------------

    // Checks every strobe of one run in wave order
    task automatic collect_run(input string test, input bit random_busy, input bit extra_start);
        int   idx;
        int   cycles;
        int   first_at;
        int   busy_cycles;
        int   lane;
        int   step;
        logic busy_at_edge;
        logic [DIM-1:0] exp_req;
        idx = 0;
        cycles = 0;
        first_at = -1;
        busy_cycles = 0;
        busy_at_edge = array_busy_i;
        while (idx < N_STROBES && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (row_req_o != '0) begin
                lane = idx % DIM;
                step = DIM - 1 - idx / DIM;
                exp_req = DIM'(1) << lane;
                if (row_req_o[0] && busy_at_edge) begin
                    report_failure(test, "a wave started on an edge where the array was busy");
                end
                check_eq(test, "row_req", exp_req, row_req_o);
                check_eq(test, "col_req", exp_req, col_req_o);
                check_slots(test, lane, step);
                check_eq(test, "done", idx == N_STROBES - 1, done_o);
                if (first_at < 0) begin
                    first_at = cycles;
                end
                idx++;
            end
            else begin
                check_eq(test, "col_req", '0, col_req_o);
                check_eq(test, "done", 1'b0, done_o);
                check_slots(test, -1, 0);
            end
            busy_at_edge = array_busy_i;    // Value the next edge will see
            if (array_busy_i) begin
                busy_cycles++;
            end
            @(posedge clk);
            #1;
            if (random_busy) begin
                if (array_busy_i) begin
                    array_busy_i = (take_bits(1) == 32'd0);
                end
                else begin
                    array_busy_i = (take_bits(2) == 32'd3);
                end
            end
            start_i = extra_start && (idx == N_STROBES / 3);
        end
        start_i = 1'b0;
        array_busy_i = 1'b0;
        if (idx < N_STROBES) begin
            report_failure(test, $sformatf("timed out after %0d of %0d strobes", idx, N_STROBES));
        end
        else if (!random_busy && (cycles - first_at != N_STROBES - 1)) begin
            report_failure(test, "strobes did not come on consecutive cycles");
        end
        if (random_busy && busy_cycles == 0) begin
            report_failure(test, "array busy was never raised during the run");
        end
        cycles = 0;
        while (ack_o && cycles < ACK_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack_o) begin
            report_failure(test, "ack stayed high after the run ended");
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset();
        int fails_before;
        fails_before = fail_count;
        @(negedge clk);
        check_eq("reset", "ack", 1'b0, ack_o);
        check_eq("reset", "done", 1'b0, done_o);
        check_eq("reset", "row_req", '0, row_req_o);
        check_eq("reset", "col_req", '0, col_req_o);
        check_slots("reset", -1, 0);
        summarize_test("reset", fails_before);
    endtask

    task automatic test_full_idle();
        int fails_before;
        fails_before = fail_count;
        array_busy_i = 1'b0;
        pulse_start();
        collect_run("full_idle", 1'b0, 1'b0);
        summarize_test("full_idle", fails_before);
    endtask

    task automatic test_busy_waves();
        int fails_before;
        fails_before = fail_count;
        pulse_start();
        collect_run("busy_waves", 1'b1, 1'b0);
        summarize_test("busy_waves", fails_before);
    endtask

    task automatic test_start_busy();
        int fails_before;
        fails_before = fail_count;
        @(posedge clk);
        #1;
        array_busy_i = 1'b1;
        pulse_start();
        repeat (10) begin
            @(negedge clk);
            check_eq("start_busy", "row_req", '0, row_req_o);
        end
        check_eq("start_busy", "ack", 1'b1, ack_o);
        @(posedge clk);
        #1;
        array_busy_i = 1'b0;
        collect_run("start_busy", 1'b0, 1'b0);
        summarize_test("start_busy", fails_before);
    endtask

    task automatic test_start_active();
        int fails_before;
        fails_before = fail_count;
        pulse_start();
        collect_run("start_active", 1'b0, 1'b1);
        for (int n = 0; n < QUIET_WIN; n++) begin
            @(negedge clk);
            check_eq("start_active", "row_req", '0, row_req_o);
            check_eq("start_active", "ack", 1'b0, ack_o);
        end
        summarize_test("start_active", fails_before);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        rst = 1'b1;
        start_i = 1'b0;
        array_busy_i = 1'b0;
        pass_count = 0;
        fail_count = 0;
        lfsr = LFSR_SEED;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                a_mat[i][j] = take_bits(32);
                b_mat[i][j] = take_bits(32);
            end
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_full_idle();
        test_busy_waves();
        test_start_busy();
        test_start_active();

        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_mpu_dispatch

// ==== sim.f ====
+incdir+source
source/dispatch_pkg.sv
source/operand_sequencer.sv
source/dispatch_fifo.sv
source/edge_driver.sv
source/mpu_dispatch_top.sv
testbench/tb_mpu_dispatch.sv
